//--- src/corePkg.sv
// core widths, data types, opcodes, ALU operations and the instruction word union
`default_nettype none

package corePkg;

  ////////////////////////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////////////////////////

  localparam int xlen     = 32;
  localparam int regAddrW = 5;

  typedef logic [xlen-1:0]     word;
  typedef logic [regAddrW-1:0] regAddr;

  localparam word resetVector = 32'h0000_0000;  // first fetch address

  ////////////////////////////////////////////////////////////
  // opcodes and function codes of the supported subset
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] opOp     = 7'b0110011;  // register-register ALU
  localparam logic [6:0] opImm    = 7'b0010011;  // register-immediate ALU
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;

  // ALU operations
  // passB carries operand B through, used by LUI and the JAL link value
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOp;

  ////////////////////////////////////////////////////////////
  // instruction word, seen as R-type or as I-type
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]  funct7;
    regAddr      rs2;
    regAddr      rs1;
    logic [2:0]  funct3;
    regAddr      rd;
    logic [6:0]  opcode;
  } rFields;

  typedef struct packed {
    logic [11:0] imm12;   // sign extended in decode
    regAddr      rs1;
    logic [2:0]  funct3;
    regAddr      rd;
    logic [6:0]  opcode;
  } iFields;

  typedef union packed {
    rFields r;
    iFields i;
  } instrWord;

endpackage

`default_nettype wire

//--- src/pipeIf.sv
// register read interface and decode/execute pipeline interface
`default_nettype none

// decode asks for two registers, the register file answers in the same cycle
interface regReadIf;
  import corePkg::*;

  regAddr rs1;
  regAddr rs2;
  word    rdata1;
  word    rdata2;

  modport dec  (output rs1, rs2, input  rdata1, rdata2);
  modport regs (input  rs1, rs2, output rdata1, rdata2);
endinterface

// decode/execute pipeline register contents
interface decExIf;
  import corePkg::*;

  logic   valid;
  word    pc;
  aluOp   op;
  regAddr rd;
  logic   regWrite;
  logic   isBranch;
  logic   branchNe;   // BNE when set, BEQ otherwise
  logic   isJump;
  logic   useImm;     // operand B from imm
  word    imm;
  regAddr rs1;        // kept for forwarding
  regAddr rs2;
  word    src1;
  word    src2;

  modport dec (
    output valid, pc, op, rd, regWrite, isBranch, branchNe, isJump, useImm, imm,
    output rs1, rs2, src1, src2
  );
  modport ex (
    input valid, pc, op, rd, regWrite, isBranch, branchNe, isJump, useImm, imm,
    input rs1, rs2, src1, src2
  );
endinterface

`default_nettype wire

//--- src/fetchUnit.sv
// fetch stage with program counter, stall and redirect handling, fetch/decode register
`default_nettype none

module fetchUnit (
  input  logic         clk,
  input  logic         rstN,
  input  corePkg::word instrF,
  input  logic         instrReady,
  input  logic         redirect,
  input  corePkg::word target,
  output corePkg::word pcF,
  output logic         valid,
  output corePkg::word pc,
  output corePkg::word instr
);
  import corePkg::*;

  logic accept;

  // a redirect edge drops whatever is on the instruction bus
  assign accept = instrReady & ~redirect;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= resetVector;
    end else if (redirect) begin
      pcF <= target;              // taken branch or jump
    end else if (instrReady) begin
      pcF <= pcF + 32'd4;
    end
    // otherwise hold until memory is ready
  end

  ////////////////////////////////////////////////////////////
  // fetch/decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      valid <= 1'b0;
    end else begin
      valid <= accept;            // bubble on stall or squash
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc    <= pcF;
      instr <= instrF;
    end
  end

endmodule

`default_nettype wire

//--- src/regFile.sv
// integer register file with 31 writable entries and write-through reads
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            rstN,
  regReadIf.regs          rd,
  input  logic            wrEn,
  input  corePkg::regAddr wrAddr,
  input  corePkg::word    wrData
);
  import corePkg::*;

  word regs [1:31];   // x0 has no storage

  // one read port, x0 reads zero, pending write shows through
  function automatic word readPort(input regAddr addr);
    word value;
    if (addr == '0) begin
      value = '0;
    end else if (wrEn && wrAddr == addr) begin
      value = wrData;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rd.rdata1 = readPort(rd.rs1);
    rd.rdata2 = readPort(rd.rs2);
  end

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;   // writes to x0 are dropped
    end
  end

endmodule

`default_nettype wire

//--- src/decodeUnit.sv
// decode stage with control decode, immediate generation, register read, decode/execute register
`default_nettype none

module decodeUnit (
  input  logic         clk,
  input  logic         rstN,
  input  logic         valid,
  input  corePkg::word pc,
  input  corePkg::word instr,
  input  logic         flush,
  regReadIf.dec        rd,
  decExIf.dec          dx
);
  import corePkg::*;

  instrWord iw;
  aluOp     opD;
  logic     regWriteD;
  logic     isBranchD;
  logic     branchNeD;
  logic     isJumpD;
  logic     useImmD;
  word      immD;
  word      immI;
  word      immU;
  word      immB;
  word      immJ;

  assign iw = instr;

  ////////////////////////////////////////////////////////////
  // immediates
  ////////////////////////////////////////////////////////////

  assign immI = {{20{iw.i.imm12[11]}}, iw.i.imm12};
  assign immU = {instr[31:12], 12'b0};
  assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // register operands read straight from the fields
  assign rd.rs1 = iw.r.rs1;
  assign rd.rs2 = iw.r.rs2;

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    opD       = aluAdd;
    regWriteD = 1'b0;
    isBranchD = 1'b0;
    branchNeD = 1'b0;
    isJumpD   = 1'b0;
    useImmD   = 1'b0;
    immD      = immI;
    case (iw.r.opcode)
      opOp: begin
        regWriteD = 1'b1;
        case (iw.r.funct3)
          f3AddSub: opD = iw.r.funct7[5] ? aluSub : aluAdd;
          f3Slt:    opD = aluSlt;
          f3Xor:    opD = aluXor;
          f3Or:     opD = aluOr;
          f3And:    opD = aluAnd;
          default:  regWriteD = 1'b0;    // outside the subset
        endcase
      end
      opImm: begin
        regWriteD = 1'b1;
        useImmD   = 1'b1;
        case (iw.i.funct3)
          f3AddSub: opD = aluAdd;
          f3Slt:    opD = aluSlt;
          f3Xor:    opD = aluXor;
          f3Or:     opD = aluOr;
          f3And:    opD = aluAnd;
          default:  regWriteD = 1'b0;
        endcase
      end
      opLui: begin
        regWriteD = 1'b1;
        useImmD   = 1'b1;
        opD       = aluPassB;
        immD      = immU;
      end
      opBranch: begin
        isBranchD = (iw.r.funct3 == f3Beq) || (iw.r.funct3 == f3Bne);
        branchNeD = iw.r.funct3 == f3Bne;
        immD      = immB;
      end
      opJal: begin
        regWriteD = 1'b1;
        isJumpD   = 1'b1;
        opD       = aluPassB;   // link value enters as operand B
        immD      = immJ;
      end
      default: ;                 // retires as a no-op
    endcase
  end

  ////////////////////////////////////////////////////////////
  // decode/execute register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dx.valid    <= 1'b0;
      dx.regWrite <= 1'b0;
      dx.isBranch <= 1'b0;
      dx.isJump   <= 1'b0;
    end else begin
      dx.valid    <= valid & ~flush;   // squash on redirect
      dx.regWrite <= regWriteD;
      dx.isBranch <= isBranchD;
      dx.isJump   <= isJumpD;
    end
  end

  always_ff @(posedge clk) begin
    dx.pc       <= pc;
    dx.op       <= opD;
    dx.rd       <= iw.r.rd;
    dx.branchNe <= branchNeD;
    dx.useImm   <= useImmD;
    dx.imm      <= immD;
    dx.rs1      <= iw.r.rs1;
    dx.rs2      <= iw.r.rs2;
    dx.src1     <= rd.rdata1;
    dx.src2     <= rd.rdata2;
  end

endmodule

`default_nettype wire

//--- src/executeUnit.sv
// execute stage with forwarding, ALU, branch resolution and the execute/writeback register
`default_nettype none

module executeUnit (
  input  logic            clk,
  input  logic            rstN,
  decExIf.ex              dx,
  output logic            redirect,
  output corePkg::word    target,
  output logic            wrEn,
  output corePkg::regAddr wrAddr,
  output corePkg::word    wrData,
  output corePkg::word    wrPc,
  output logic            wrValid
);
  import corePkg::*;

  word  fwdA;
  word  fwdB;
  word  aluB;
  word  linkPc;
  word  result;
  logic equal;
  logic taken;
  logic writes;

  ////////////////////////////////////////////////////////////
  // operand forwarding from the writeback register
  ////////////////////////////////////////////////////////////

  // wrEn already excludes x0
  assign fwdA = (wrEn && wrAddr == dx.rs1) ? wrData : dx.src1;
  assign fwdB = (wrEn && wrAddr == dx.rs2) ? wrData : dx.src2;

  assign linkPc = dx.pc + 32'd4;

  always_comb begin
    if (dx.isJump) begin
      aluB = linkPc;
    end else if (dx.useImm) begin
      aluB = dx.imm;
    end else begin
      aluB = fwdB;
    end
  end

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dx.op)
      aluAdd:   result = fwdA + aluB;
      aluSub:   result = fwdA - aluB;
      aluAnd:   result = fwdA & aluB;
      aluOr:    result = fwdA | aluB;
      aluXor:   result = fwdA ^ aluB;
      aluSlt:   result = {31'b0, $signed(fwdA) < $signed(aluB)};
      aluPassB: result = aluB;
      default:  result = '0;
    endcase
  end

  // branch outcome
  // compares register operands, never the immediate
  assign equal    = fwdA == fwdB;
  assign taken    = dx.isJump | (dx.isBranch & (equal ^ dx.branchNe));
  assign redirect = dx.valid & taken;
  assign target   = dx.pc + dx.imm;   // same adder form for B and J offsets

  ////////////////////////////////////////////////////////////
  // execute/writeback register
  ////////////////////////////////////////////////////////////

  assign writes = dx.valid & dx.regWrite & (dx.rd != '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrValid <= 1'b0;
      wrEn    <= 1'b0;
    end else begin
      wrValid <= dx.valid;
      wrEn    <= writes;
    end
  end

  // no-write retirements report rd and data as zero
  always_ff @(posedge clk) begin
    wrAddr <= writes ? dx.rd : '0;
    wrData <= writes ? result : '0;
    wrPc   <= dx.pc;
  end

endmodule

`default_nettype wire

//--- src/rvCore.sv
// top level of the four stage core, wiring fetch, decode, register file and execute
`default_nettype none

module rvCore (
  input  logic            clk,
  input  logic            rstN,
  output corePkg::word    pcF,
  input  corePkg::word    instrF,
  input  logic            instrReady,
  output logic            retValid,
  output corePkg::word    retPc,
  output corePkg::regAddr retRd,
  output corePkg::word    retData
);
  import corePkg::*;

  logic redirect;   // also flushes decode
  word  target;
  logic validD;
  word  pcD;
  word  instrD;
  logic wrEn;

  regReadIf regRd ();
  decExIf   decEx ();

  // fetch and fetch/decode register
  fetchUnit fetch (
    .clk, .rstN,
    .instrF, .instrReady, .redirect, .target,
    .pcF, .valid(validD), .pc(pcD), .instr(instrD)
  );

  decodeUnit decode (
    .clk, .rstN,
    .valid(validD), .pc(pcD), .instr(instrD), .flush(redirect),
    .rd(regRd), .dx(decEx)
  );

  // writeback lands here, same signals as the retire port
  regFile rf (
    .clk, .rstN,
    .rd(regRd),
    .wrEn, .wrAddr(retRd), .wrData(retData)
  );

  executeUnit execute (
    .clk, .rstN,
    .dx(decEx),
    .redirect, .target,
    .wrEn, .wrAddr(retRd), .wrData(retData), .wrPc(retPc), .wrValid(retValid)
  );

endmodule

`default_nettype wire

//--- test/coreAssert.sv
// concurrent assertions on reset, decode flush and fetch stall behavior of the core
`default_nettype none

module coreAssert (
  input logic         clk,
  input logic         rstN,
  input logic         instrReady,
  input logic         redirect,
  input logic         dxValid,
  input logic         retValid,
  input corePkg::word pcF
);
  int failCount = 0;   // failed assertions so far

  // nothing retires straight out of reset
  retireAfterReset: assert property (@(posedge clk) !rstN |=> !retValid)
    else begin
      failCount++;
      $error("retValid high in the cycle after reset");
    end

  // taken branch squashes the younger instruction in decode
  flushDecode: assert property (@(posedge clk) disable iff (!rstN) redirect |=> !dxValid)
    else begin
      failCount++;
      $error("decode/execute valid high after a redirect");
    end

  pcHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
                                  (!instrReady && !redirect) |=> $stable(pcF))
    else begin
      failCount++;
      $error("pcF moved while instruction memory was not ready");
    end

endmodule

`default_nettype wire

//--- test/coreTb.sv
// core testbench with instruction memory, reference instruction-set model and retire checker
`default_nettype none

module coreTb;
  import corePkg::*;

  localparam int retireTarget = 200;
  localparam int cycleLimit   = 2000;   // 200 retirements at about 3 cycles, plus margin

  logic        clk;
  logic        rstN;
  logic        instrReady;
  word         instrF;
  word         pcF;
  logic        retValid;
  word         retPc;
  regAddr      retRd;
  word         retData;

  word         prog [0:63];
  int          progLen;
  word         mPc;            // model program counter
  word         mRegs [0:31];   // model registers, x0 never written
  logic [31:0] rng;
  logic        accepted;
  int          errors;
  int          retired;
  int          cycles;

  rvCore DUT (
    .clk, .rstN,
    .pcF, .instrF, .instrReady,
    .retValid, .retPc, .retRd, .retData
  );

  bind rvCore coreAssert checks (
    .clk(clk),
    .rstN(rstN),
    .instrReady(instrReady),
    .redirect(redirect),
    .dxValid(decEx.valid),
    .retValid(retValid),
    .pcF(pcF)
  );

  ////////////////////////////////////////////////////////////
  // instruction encoders and memory
  ////////////////////////////////////////////////////////////

  function automatic word encR(input logic [6:0] f7, input logic [2:0] f3,
                               input regAddr rd, input regAddr rs1, input regAddr rs2);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic word encI(input logic [2:0] f3, input regAddr rd,
                               input regAddr rs1, input int imm);
    logic [11:0] v;
    v = imm[11:0];
    return {v, rs1, f3, rd, opImm};
  endfunction

  function automatic word encU(input regAddr rd, input logic [19:0] upper);
    return {upper, rd, opLui};
  endfunction

  function automatic word encB(input logic [2:0] f3, input regAddr rs1,
                               input regAddr rs2, input int off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], opBranch};
  endfunction

  function automatic word encJ(input regAddr rd, input int off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, opJal};
  endfunction

  // outside the program every word jumps to itself
  function automatic word fetchWord(input word addr);
    word w;
    if (addr[1:0] == 2'b00 && addr[31:2] < progLen) begin
      w = prog[addr[31:2]];
    end else begin
      w = encJ(0, 0);
    end
    return w;
  endfunction

  always_comb instrF = fetchWord(pcF);

  task automatic append(input word w);
    prog[progLen] = w;
    progLen++;
  endtask

  task automatic loadProgram();
    progLen = 0;
    append(encI(f3AddSub, 1, 0, 5));
    append(encI(f3AddSub, 2, 0, -3));
    append(encR(7'h00, f3AddSub, 3, 1, 2));   // x1 via regfile, x2 via forward
    append(encR(7'h20, f3AddSub, 4, 3, 1));
    append(encR(7'h00, f3And, 5, 4, 2));
    append(encR(7'h00, f3Or, 6, 5, 1));
    append(encR(7'h00, f3Xor, 7, 6, 2));
    append(encR(7'h00, f3Slt, 8, 2, 1));
    append(encR(7'h00, f3Slt, 9, 1, 2));
    append(encI(f3Slt, 10, 2, -1));
    append(encI(f3Xor, 11, 7, 'h555));
    append(encI(f3Or, 12, 11, -256));
    append(encI(f3And, 13, 12, 'h0f0));
    append(encU(14, 20'habcde));
    append(encI(f3AddSub, 14, 14, 'h123));
    append(encR(7'h00, f3AddSub, 0, 1, 1));   // x0 writes dropped
    append(encI(f3AddSub, 0, 0, 7));
    append(encR(7'h00, f3AddSub, 15, 0, 1));
    append(encB(f3Beq, 1, 2, 8));             // not taken
    append(encB(f3Bne, 1, 2, 8));             // taken
    append(encI(f3AddSub, 16, 0, 99));        // squashed
    append(encB(f3Beq, 3, 3, 8));
    append(encI(f3AddSub, 17, 0, 77));        // squashed
    append(encJ(18, 8));
    append(encI(f3AddSub, 19, 0, 55));        // squashed
    append(encB(f3Bne, 0, 0, 8));             // not taken
    append(encI(f3AddSub, 1, 1, 1));
    append(32'h0000_100f);                    // unsupported opcode
    append(encR(7'h00, 3'b001, 20, 1, 2));    // shift, outside the subset
    append(encR(7'h00, f3AddSub, 21, 18, 1)); // uses link value
    append(encR(7'h00, f3Xor, 22, 21, 14));
    append(encR(7'h20, f3AddSub, 23, 0, 22));
    append(encI(f3AddSub, 24, 24, 1));        // pass counter
    append(encI(f3AddSub, 25, 0, 5));
    append(encB(f3Beq, 24, 25, 8));           // exit after five passes
    append(encJ(0, -140));                    // back to 0
    append(encJ(26, 16));                     // off the end of the program
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and random ready
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // executes one instruction of the model, returns what should retire
  function automatic void stepModel(output word expPc, output regAddr expRd,
                                    output word expData);
    word  ins;
    word  a;
    word  b;
    word  immI;
    word  immB;
    word  immJ;
    word  res;
    word  nextPc;
    logic wr;
    ins    = fetchWord(mPc);
    a      = mRegs[ins[19:15]];
    b      = mRegs[ins[24:20]];
    immI   = {{20{ins[31]}}, ins[31:20]};
    immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res    = '0;
    wr     = 1'b0;
    nextPc = mPc + 32'd4;
    case (ins[6:0])
      opOp, opImm: begin
        if (ins[6:0] == opImm) begin
          b = immI;
        end
        wr = 1'b1;
        case (ins[14:12])
          3'b000:  res = (ins[6:0] == opOp && ins[30]) ? a - b : a + b;
          3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  res = a ^ b;
          3'b110:  res = a | b;
          3'b111:  res = a & b;
          default: wr = 1'b0;
        endcase
      end
      opLui: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'b0};
      end
      opBranch: begin
        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
          nextPc = mPc + immB;
        end
      end
      opJal: begin
        wr     = 1'b1;
        res    = mPc + 32'd4;
        nextPc = mPc + immJ;
      end
      default: ;   // no-op
    endcase
    expPc = mPc;
    if (wr && ins[11:7] != 5'd0) begin
      expRd            = ins[11:7];
      expData          = res;
      mRegs[ins[11:7]] = res;
    end else begin
      expRd   = '0;
      expData = '0;
    end
    mPc = nextPc;
  endfunction

  ////////////////////////////////////////////////////////////
  // clock, reset and stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : stimulus
    rstN       = 1'b0;
    instrReady = 1'b0;
    accepted   = 1'b0;
    rng        = 32'h2790_e913;
    loadProgram();
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    forever begin
      rng        = xorshift(rng);
      instrReady = (rng % 32'd100) < 32'd60;   // ready about 60% of cycles
      @(posedge clk);
      #1;
    end
  end

  // first instruction taken by fetch
  always @(posedge clk) begin
    if (rstN && instrReady) begin
      accepted <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // retire checker
  ////////////////////////////////////////////////////////////

  initial begin : retireCheck
    word    expPc;
    regAddr expRd;
    word    expData;
    errors  = 0;
    retired = 0;
    cycles  = 0;
    mPc     = resetVector;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
    @(posedge rstN);
    @(negedge clk);
    if (pcF !== resetVector) begin
      errors++;
      $display("** Error: pcF expected %h observed %h after reset", resetVector, pcF);
    end
    while (retired < retireTarget && cycles < cycleLimit) begin
      if (retValid === 1'b1) begin
        if (!accepted) begin
          errors++;
          $display("retValid went high before any instruction was fetched");
        end
        stepModel(expPc, expRd, expData);
        if (retPc !== expPc) begin
          errors++;
          $display("** Error: retPc expected %h observed %h", expPc, retPc);
        end
        if (retRd !== expRd) begin
          errors++;
          $display("** Error: retRd expected %h observed %h", expRd, retRd);
        end
        if (retData !== expData) begin
          errors++;
          $display("** Error: retData expected %h observed %h", expData, retData);
        end
        retired++;
      end else if (retValid !== 1'b0) begin
        errors++;
        $display("retValid is neither high nor low at cycle %0d", cycles);
      end
      cycles++;
      @(negedge clk);
    end
    if (retired < retireTarget) begin
      errors++;
      $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
               retired, retireTarget, cycles);
    end
    errors += DUT.checks.failCount;
    $display("Summary: %0d errors, %0d retirements, %0d cycles", errors, retired, cycles);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/corePkg.sv
src/pipeIf.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeUnit.sv
src/executeUnit.sv
src/rvCore.sv
test/coreAssert.sv
test/coreTb.sv

//--- Bender.yml
package:
  name: rvcore

sources:
  # synthesizable core, package first
  - files:
      - src/corePkg.sv
      - src/pipeIf.sv
      - src/fetchUnit.sv
      - src/regFile.sv
      - src/decodeUnit.sv
      - src/executeUnit.sv
      - src/rvCore.sv

  # simulation only
  - target: test
    files:
      - test/coreAssert.sv
      - test/coreTb.sv
